// ==== common/ooo_pkg.sv ====
package ooo_pkg;

   localparam int DATA_W     = 32;
   localparam int INSTR_W    = 32;
   localparam int REG_ADDR_W = 3;
   localparam int ROB_DEPTH  = 8;
   localparam int TAG_W      = $clog2(ROB_DEPTH);
   localparam int RS_DEPTH   = 4;
   localparam int RS_IDX_W   = $clog2(RS_DEPTH);

   // Instruction layout, opcode on top then rd, rs1, rs2
   localparam int OPC_W    = 3;
   localparam int OPC_POS  = INSTR_W - OPC_W;
   localparam int RD_POS   = OPC_POS - REG_ADDR_W;
   localparam int RS1_POS  = RD_POS - REG_ADDR_W;
   localparam int RS2_POS  = RS1_POS - REG_ADDR_W;
   localparam int IMM_W    = 16;
   localparam int IMM_POS  = 0;

   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [INSTR_W-1:0]    instr_t;

   typedef enum logic [OPC_W-1:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      ADDI,
      SUBI,
      SETI
   } opcode_e;

   // Value is valid when filled, else tag names the producer
   typedef struct packed {
      logic  filled;
      tag_t  tag;
      data_t value;
   } operand_t;

   typedef struct packed {
      tag_t     dst;
      opcode_e  op;
      operand_t a;
      operand_t b;
   } rs_entry_t;

   typedef struct packed {
      tag_t  tag;
      data_t value;
   } cdb_t;

   typedef struct packed {
      tag_t      tag;
      reg_addr_t dst;
      data_t     value;
   } commit_t;

endpackage

// ==== design/dispatch_unit.sv ====
module dispatch_unit import ooo_pkg::*; (
   input  instr_t          i_instr,
   input  logic            i_instr_valid,
   input  logic            i_rob_full,
   input  tag_t            i_rob_tag,
   input  logic            i_station_free,
   input  operand_t [1:0]  i_reg_ops,
   input  data_t [1:0]     i_rob_vals,
   input  logic [1:0]      i_rob_done,
   input  cdb_t            i_cdb,
   input  logic            i_cdb_valid,
   output logic            o_instr_ready,
   output logic            o_reserve,
   output rs_entry_t       o_entry,
   output logic            o_alloc,
   output reg_addr_t       o_alloc_dst,
   output reg_addr_t [1:0] o_src_regs,
   output tag_t [1:0]      o_src_tags,
   output logic            o_rename
);

   opcode_e        opcode;
   data_t          imm;
   operand_t       imm_op;
   operand_t       zero_op;
   operand_t [1:0] src_ops;
   logic           accept;

   assign opcode        = opcode_e'(i_instr[OPC_POS +: OPC_W]);
   assign o_alloc_dst   = i_instr[RD_POS +: REG_ADDR_W];
   assign o_src_regs[0] = i_instr[RS1_POS +: REG_ADDR_W];
   assign o_src_regs[1] = i_instr[RS2_POS +: REG_ADDR_W];
   assign imm           = data_t'(i_instr[IMM_POS +: IMM_W]);

   assign imm_op  = '{filled: 1'b1, tag: '0, value: imm};
   assign zero_op = '{filled: 1'b1, tag: '0, value: '0};

   // Operand bypass, CDB first, then register file, then ROB
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         o_src_tags[i] = i_reg_ops[i].tag;
         if (!i_reg_ops[i].filled && i_cdb_valid && i_cdb.tag == i_reg_ops[i].tag) begin
            src_ops[i] = '{filled: 1'b1, tag: i_cdb.tag, value: i_cdb.value};
         end else if (i_reg_ops[i].filled) begin
            src_ops[i] = i_reg_ops[i];
         end else if (i_rob_done[i]) begin
            src_ops[i] = '{filled: 1'b1, tag: i_reg_ops[i].tag, value: i_rob_vals[i]};
         end else begin
            src_ops[i] = '{filled: 1'b0, tag: i_reg_ops[i].tag, value: '0};
         end
      end
   end

   always_comb begin
      o_entry.dst = i_rob_tag;
      o_entry.op  = opcode;
      o_entry.a   = src_ops[0];
      o_entry.b   = src_ops[1];
      case (opcode)
         ADDI, SUBI: begin
            o_entry.b = imm_op;
         end
         SETI: begin
            o_entry.a = imm_op;
            o_entry.b = zero_op;
         end
         default: begin
         end
      endcase
   end

   assign o_instr_ready = !i_rob_full && i_station_free;
   assign accept        = i_instr_valid && o_instr_ready;

   // ROB slot, rename and station write all land on the same edge
   assign o_alloc   = accept;
   assign o_reserve = accept;
   assign o_rename  = accept;

endmodule

// ==== design/register_file.sv ====
module register_file import ooo_pkg::*; (
   input  logic            clk,
   input  logic            nrst,
   input  reg_addr_t [1:0] i_src_regs,
   input  logic            i_rename,
   input  reg_addr_t       i_rename_dst,
   input  tag_t            i_rename_tag,
   input  commit_t         i_commit,
   input  logic            i_commit_valid,
   output operand_t [1:0]  o_ops
);

   localparam int N_REGS = 2 ** REG_ADDR_W;

   data_t             values [N_REGS];
   tag_t              tags [N_REGS];
   logic [N_REGS-1:0] busy;

   always_ff @(posedge clk) begin
      if (nrst) begin
         busy <= '0;
         for (int i = 0; i < N_REGS; i++) begin
            values[i] <= '0;
         end
      end else begin
         if (i_commit_valid) begin
            values[i_commit.dst] <= i_commit.value;
            // Only the youngest producer releases the register
            if (tags[i_commit.dst] == i_commit.tag) begin
               busy[i_commit.dst] <= 1'b0;
            end
         end
         if (i_rename) begin
            busy[i_rename_dst] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rename) begin
         tags[i_rename_dst] <= i_rename_tag;
      end
   end

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         o_ops[i].filled = !busy[i_src_regs[i]];
         o_ops[i].tag    = tags[i_src_regs[i]];
         o_ops[i].value  = values[i_src_regs[i]];
      end
   end

endmodule

// ==== design/alu_station/alu_station.sv ====
module alu_station import ooo_pkg::*; (
   input  logic      clk,
   input  logic      nrst,
   input  logic      i_reserve,
   input  rs_entry_t i_entry,
   input  cdb_t      i_cdb,
   input  logic      i_cdb_valid,
   output logic      o_free,
   output cdb_t      o_cdb,
   output logic      o_cdb_valid
);

   rs_entry_t           entries [RS_DEPTH];
   logic [RS_DEPTH-1:0] valid;
   logic [RS_DEPTH-1:0] ready;
   logic [RS_IDX_W-1:0] free_idx;
   logic [RS_IDX_W-1:0] issue_idx;
   logic                issue;

   function automatic data_t alu_op(opcode_e op, data_t a, data_t b);
      case (op)
         ADD, ADDI: return a + b;
         SUB, SUBI: return a - b;
         AND:       return a & b;
         OR:        return a | b;
         XOR:       return a ^ b;
         default:   return a;
      endcase
   endfunction

   always_comb begin
      for (int i = 0; i < RS_DEPTH; i++) begin
         ready[i] = valid[i] && entries[i].a.filled && entries[i].b.filled;
      end
   end

   // Walk down so the lowest index wins
   always_comb begin
      free_idx  = '0;
      issue_idx = '0;
      for (int i = RS_DEPTH - 1; i >= 0; i--) begin
         if (!valid[i]) begin
            free_idx = RS_IDX_W'(i);
         end
         if (ready[i]) begin
            issue_idx = RS_IDX_W'(i);
         end
      end
   end

   assign issue  = |ready;
   assign o_free = ~&valid;

   always_ff @(posedge clk) begin
      if (nrst) begin
         valid <= '0;
      end else begin
         if (issue) begin
            valid[issue_idx] <= 1'b0;
         end
         if (i_reserve) begin
            valid[free_idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
         if (i_cdb_valid && !entries[i].a.filled && entries[i].a.tag == i_cdb.tag) begin
            entries[i].a.filled <= 1'b1;
            entries[i].a.value  <= i_cdb.value;
         end
         if (i_cdb_valid && !entries[i].b.filled && entries[i].b.tag == i_cdb.tag) begin
            entries[i].b.filled <= 1'b1;
            entries[i].b.value  <= i_cdb.value;
         end
      end
      if (i_reserve) begin
         entries[free_idx] <= i_entry;
      end
   end

   // Result goes out on the CDB the cycle after issue
   always_ff @(posedge clk) begin
      if (nrst) begin
         o_cdb_valid <= 1'b0;
      end else begin
         o_cdb_valid <= issue;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         o_cdb.tag   <= entries[issue_idx].dst;
         o_cdb.value <= alu_op(entries[issue_idx].op, entries[issue_idx].a.value,
                               entries[issue_idx].b.value);
      end
   end

endmodule

// ==== design/reorder_buffer/reorder_buffer.sv ====
module reorder_buffer import ooo_pkg::*; (
   input  logic           clk,
   input  logic           nrst,
   input  logic           i_alloc,
   input  reg_addr_t      i_alloc_dst,
   input  tag_t [1:0]     i_src_tags,
   input  cdb_t           i_cdb,
   input  logic           i_cdb_valid,
   output logic           o_full,
   output tag_t           o_tag,
   output data_t [1:0]    o_vals,
   output logic [1:0]     o_done,
   output commit_t        o_commit,
   output logic           o_commit_valid
);

   data_t                values [ROB_DEPTH];
   reg_addr_t            dsts [ROB_DEPTH];
   logic [ROB_DEPTH-1:0] done;
   tag_t                 head;
   tag_t                 tail;
   logic [TAG_W:0]       count;
   logic                 commit;

   assign o_full = count == (TAG_W + 1)'(ROB_DEPTH);
   assign o_tag  = tail;

   // In-order retire, head leaves once its result is back
   assign commit         = count != '0 && done[head];
   assign o_commit_valid = commit;
   assign o_commit.tag   = head;
   assign o_commit.dst   = dsts[head];
   assign o_commit.value = values[head];

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         o_vals[i] = values[i_src_tags[i]];
         o_done[i] = done[i_src_tags[i]];
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (i_alloc) begin
            tail <= tail + 1'b1;
         end
         if (commit) begin
            head <= head + 1'b1;
         end
         case ({i_alloc, commit})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Tail is never an in-flight tag, so alloc and CDB never collide
   always_ff @(posedge clk) begin
      if (nrst) begin
         done <= '0;
      end else begin
         if (i_alloc) begin
            done[tail] <= 1'b0;
         end
         if (i_cdb_valid) begin
            done[i_cdb.tag] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_alloc) begin
         dsts[tail] <= i_alloc_dst;
      end
      if (i_cdb_valid) begin
         values[i_cdb.tag] <= i_cdb.value;
      end
   end

endmodule

// ==== design/core_top.sv ====
module core_top import ooo_pkg::*; (
   input  logic    clk,
   input  logic    nrst,
   input  instr_t  i_instr,
   input  logic    i_instr_valid,
   output logic    o_instr_ready,
   output commit_t o_commit,
   output logic    o_commit_valid
);

   rs_entry_t            entry;
   logic                 reserve;
   logic                 station_free;
   logic                 alloc;
   reg_addr_t            alloc_dst;
   logic                 rob_full;
   tag_t                 rob_tag;
   reg_addr_t [1:0]      src_regs;
   operand_t [1:0]       reg_ops;
   tag_t [1:0]           src_tags;
   data_t [1:0]          rob_vals;
   logic [1:0]           rob_done;
   logic                 rename;
   cdb_t                 cdb;
   logic                 cdb_valid;

   dispatch_unit dispatch_i (
      .i_instr        (i_instr),
      .i_instr_valid  (i_instr_valid),
      .i_rob_full     (rob_full),
      .i_rob_tag      (rob_tag),
      .i_station_free (station_free),
      .i_reg_ops      (reg_ops),
      .i_rob_vals     (rob_vals),
      .i_rob_done     (rob_done),
      .i_cdb          (cdb),
      .i_cdb_valid    (cdb_valid),
      .o_instr_ready  (o_instr_ready),
      .o_reserve      (reserve),
      .o_entry        (entry),
      .o_alloc        (alloc),
      .o_alloc_dst    (alloc_dst),
      .o_src_regs     (src_regs),
      .o_src_tags     (src_tags),
      .o_rename       (rename)
   );

   register_file regs_i (
      .clk            (clk),
      .nrst           (nrst),
      .i_src_regs     (src_regs),
      .i_rename       (rename),
      .i_rename_dst   (alloc_dst),
      .i_rename_tag   (rob_tag),
      .i_commit       (o_commit),
      .i_commit_valid (o_commit_valid),
      .o_ops          (reg_ops)
   );

   // Single unit, so the station owns the CDB and sees its own results
   alu_station alu_i (
      .clk         (clk),
      .nrst        (nrst),
      .i_reserve   (reserve),
      .i_entry     (entry),
      .i_cdb       (cdb),
      .i_cdb_valid (cdb_valid),
      .o_free      (station_free),
      .o_cdb       (cdb),
      .o_cdb_valid (cdb_valid)
   );

   reorder_buffer rob_i (
      .clk            (clk),
      .nrst           (nrst),
      .i_alloc        (alloc),
      .i_alloc_dst    (alloc_dst),
      .i_src_tags     (src_tags),
      .i_cdb          (cdb),
      .i_cdb_valid    (cdb_valid),
      .o_full         (rob_full),
      .o_tag          (rob_tag),
      .o_vals         (rob_vals),
      .o_done         (rob_done),
      .o_commit       (o_commit),
      .o_commit_valid (o_commit_valid)
   );

endmodule

// ==== dv/core_props.sv ====
module core_props import ooo_pkg::*; (
   input logic           clk,
   input logic           nrst,
   input logic           i_commit_valid,
   input tag_t           i_commit_tag,
   input logic [TAG_W:0] i_count
);

   tag_t next_tag;

   // Tag expected on the next commit
   always_ff @(posedge clk) begin
      if (nrst) begin
         next_tag <= '0;
      end else if (i_commit_valid) begin
         next_tag <= next_tag + 1'b1;
      end
   end

   no_commit_in_reset: assert property (@(posedge clk) nrst && $past(nrst) |-> !i_commit_valid)
      else $error("commit valid while reset is asserted");

   count_in_range: assert property (@(posedge clk) disable iff (nrst)
      i_count <= (TAG_W + 1)'(ROB_DEPTH))
      else $error("reorder buffer count above its depth");

   commit_tag_in_order: assert property (@(posedge clk) disable iff (nrst)
      i_commit_valid |-> i_commit_tag == next_tag)
      else $error("commit tag did not advance by one");

endmodule

// ==== dv/core_tb.sv ====
module core_tb import ooo_pkg::*; ();

   typedef struct {
      instr_t    instr;
      reg_addr_t dst;
      data_t     value;
      bit        gap;
      bit        burst;
      bit        drain;
   } row_t;

   logic    clk;
   logic    nrst;
   instr_t  i_instr;
   logic    i_instr_valid;
   logic    o_instr_ready;
   commit_t o_commit;
   logic    o_commit_valid;

   row_t  rows[$];
   data_t model_regs [8] = '{default: '0};
   int    n_accepted = 0;
   int    n_commits = 0;
   bit    ready_dropped = 0;

   core_top dut_i (
      .clk            (clk),
      .nrst           (nrst),
      .i_instr        (i_instr),
      .i_instr_valid  (i_instr_valid),
      .o_instr_ready  (o_instr_ready),
      .o_commit       (o_commit),
      .o_commit_valid (o_commit_valid)
   );

   bind reorder_buffer core_props props_i (
      .clk            (clk),
      .nrst           (nrst),
      .i_commit_valid (o_commit_valid),
      .i_commit_tag   (o_commit.tag),
      .i_count        (count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Testbench failed");
      $fatal(1, "run stopped");
   endtask

   task automatic report_failure(input string what);
      stop_run($sformatf("ERROR at time %0t: %s", $time, what));
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         stop_run($sformatf("MISMATCH at time %0t: %s expected 0x%0h, got 0x%0h",
                            $time, name, expected, actual));
      end
   endtask

   // In-order ISA model
   function automatic data_t model_result(opcode_e op, data_t a, data_t b, logic [15:0] imm);
      case (op)
         ADD:     return a + b;
         SUB:     return a - b;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         ADDI:    return a + {16'h0, imm};
         SUBI:    return a - {16'h0, imm};
         SETI:    return {16'h0, imm};
         default: return '0;
      endcase
   endfunction

   task automatic push_instr(input opcode_e op, input reg_addr_t rd, input reg_addr_t rs1,
                             input reg_addr_t rs2, input logic [15:0] imm,
                             input bit gap, input bit burst);
      row_t row;
      row.instr = '0;
      row.instr[OPC_POS +: OPC_W]      = op;
      row.instr[RD_POS +: REG_ADDR_W]  = rd;
      row.instr[RS1_POS +: REG_ADDR_W] = rs1;
      row.instr[RS2_POS +: REG_ADDR_W] = rs2;
      row.instr[IMM_POS +: IMM_W]      = imm;
      row.dst   = rd;
      row.value = model_result(op, model_regs[rs1], model_regs[rs2], imm);
      row.gap   = gap;
      row.burst = burst;
      row.drain = 1'b0;
      model_regs[rd] = row.value;
      rows.push_back(row);
   endtask

   task automatic build_table();
      int k;
      // Unwritten registers read as zero
      push_instr(SUB, 3'd1, 3'd2, 3'd3, 16'h0, 0, 0);
      // One of each opcode
      push_instr(SETI, 3'd1, 3'd0, 3'd0, 16'h1234, 0, 0);
      push_instr(SETI, 3'd2, 3'd0, 3'd0, 16'hff0f, 0, 0);
      push_instr(ADD, 3'd3, 3'd1, 3'd2, 16'h0, 0, 0);
      push_instr(SUB, 3'd4, 3'd1, 3'd2, 16'h0, 0, 0);
      push_instr(AND, 3'd5, 3'd1, 3'd2, 16'h0, 0, 0);
      push_instr(OR, 3'd6, 3'd1, 3'd2, 16'h0, 0, 0);
      push_instr(XOR, 3'd7, 3'd1, 3'd2, 16'h0, 0, 0);
      push_instr(ADDI, 3'd3, 3'd3, 3'd0, 16'h0010, 0, 0);
      push_instr(SUBI, 3'd4, 3'd4, 3'd0, 16'h7fff, 0, 0);
      // Back-to-back dependent chain
      push_instr(ADDI, 3'd1, 3'd1, 3'd0, 16'h0001, 0, 0);
      push_instr(ADD, 3'd2, 3'd1, 3'd1, 16'h0, 0, 0);
      push_instr(SUB, 3'd3, 3'd2, 3'd1, 16'h0, 0, 0);
      push_instr(XOR, 3'd1, 3'd3, 3'd2, 16'h0, 0, 0);
      push_instr(ADDI, 3'd1, 3'd1, 3'd0, 16'h0003, 0, 0);
      push_instr(OR, 3'd5, 3'd1, 3'd3, 16'h0, 0, 0);
      // Burst, the chain at the front holds the ROB head
      for (k = 0; k < 6; k++) begin
         push_instr(ADDI, 3'd1, 3'd1, 3'd0, 16'h0001, 0, 1);
      end
      for (k = 0; k < 10; k++) begin
         push_instr(SETI, reg_addr_t'(2 + k % 6), 3'd0, 3'd0, 16'(16'h0100 + k), 0, 1);
      end
      // Random ops with random idle gaps
      for (k = 0; k < 14; k++) begin
         push_instr(opcode_e'(3'($urandom % 8)), reg_addr_t'($urandom % 8),
                    reg_addr_t'($urandom % 8), reg_addr_t'($urandom % 8),
                    16'($urandom), 1, 0);
      end
      // Two writes to r5 in flight, then a read of r5
      push_instr(SETI, 3'd5, 3'd0, 3'd0, 16'haaaa, 0, 0);
      push_instr(SETI, 3'd5, 3'd0, 3'd0, 16'h5555, 0, 0);
      push_instr(ADDI, 3'd6, 3'd5, 3'd0, 16'h0000, 0, 0);
      // Read r5 again from the register file once both writes retire
      push_instr(ADDI, 3'd7, 3'd5, 3'd0, 16'h0000, 0, 0);
      rows[rows.size() - 1].drain = 1'b1;
   endtask

   // Starts and ends on a falling edge
   task automatic send_instr(input row_t row);
      int  idle;
      int  waits;
      bit  accepted;
      if (row.drain) begin
         waits = 0;
         while (n_commits < n_accepted) begin
            @(negedge clk);
            waits++;
            if (waits > 100) begin
               report_failure("in-flight instructions did not retire within 100 cycles");
            end
         end
      end
      if (row.gap) begin
         idle = $urandom % 4;
         repeat (idle) @(negedge clk);
      end
      i_instr       = row.instr;
      i_instr_valid = 1'b1;
      waits    = 0;
      accepted = 0;
      while (!accepted) begin
         @(posedge clk);
         if (o_instr_ready) begin
            accepted = 1;
            n_accepted++;
         end else begin
            if (row.burst) begin
               ready_dropped = 1;
            end
            waits++;
            if (waits > 100) begin
               report_failure("o_instr_ready stayed low for 100 cycles");
            end
         end
      end
      @(negedge clk);
      i_instr_valid = 1'b0;
   endtask

   // Commit monitor
   always @(posedge clk) begin
      if (!nrst && o_commit_valid) begin
         if (n_commits >= n_accepted) begin
            report_failure("commit seen with no accepted instruction left to retire");
         end
         check_value("o_commit.dst", 32'(rows[n_commits].dst), 32'(o_commit.dst));
         check_value("o_commit.value", rows[n_commits].value, o_commit.value);
         check_value("o_commit.tag", 32'(n_commits % ROB_DEPTH), 32'(o_commit.tag));
         n_commits++;
      end
   end

   initial begin
      int i;
      int waits;
      void'($urandom(32'h2da0));
      i_instr       = '0;
      i_instr_valid = 1'b0;
      nrst          = 1'b1;
      build_table();
      repeat (4) @(posedge clk);
      @(negedge clk);
      nrst = 1'b0;
      @(posedge clk);
      check_value("o_instr_ready", 32'd1, 32'(o_instr_ready));
      // Idle cycles, any commit here is flagged by the monitor
      repeat (6) @(negedge clk);
      for (i = 0; i < rows.size(); i++) begin
         send_instr(rows[i]);
      end
      waits = 0;
      while (n_commits < rows.size()) begin
         @(posedge clk);
         waits++;
         if (waits > 400) begin
            report_failure("not all instructions committed within 400 cycles");
         end
      end
      // Drain to catch duplicated commits
      repeat (10) @(posedge clk);
      if (!ready_dropped) begin
         report_failure("o_instr_ready never dropped during the burst");
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

// ==== project.f ====
common/ooo_pkg.sv
design/dispatch_unit.sv
design/register_file.sv
design/alu_station/alu_station.sv
design/reorder_buffer/reorder_buffer.sv
design/core_top.sv
dv/core_props.sv
dv/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module core_tb -f project.f -o core_sim

# A $fatal or a failed assertion gives a non-zero exit status
./obj_dir/core_sim
